/* verilog/fetch_types_pkg.sv */
package fetch_types_pkg;

    //////////////////////////////////////////////////
    // fetch path data widths
    //////////////////////////////////////////////////

    // one buffer line, byte 0 in bits 7:0
    typedef logic [127:0] line_t;

    // buffer instruction pointer
    // [5:4] selects the line, [3:0] the byte in it
    typedef logic [5:0] bip_t;

    // ring slot number
    typedef logic [1:0] line_idx_t;

    // decoded length, only [5:0] reach the pointer add
    typedef logic [7:0] len_t;

    // aligned packet for decode, byte 0 is the byte at bip
    typedef logic [127:0] packet_t;

endpackage

/* verilog/fetch_ctrl_pkg.sv */
package fetch_ctrl_pkg;

    //////////////////////////////////////////////////
    // ring geometry
    //////////////////////////////////////////////////

    // four lines of sixteen bytes, 64 bytes addressed by a 6-bit bip
    localparam int NUM_LINES  = 4;
    localparam int LINE_BYTES = 16;

    //////////////////////////////////////////////////
    // control-flow source
    //////////////////////////////////////////////////

    // encoded so a larger value means a higher priority
    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,
        CF_BRANCH  = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_src_t;

endpackage

/* verilog/ibuf_wr_if.sv */
`timescale 1ns/1ps

interface ibuf_wr_if
    import fetch_types_pkg::*;
();

    // write strobe, target slot and line data
    logic      wr_en;
    line_idx_t wr_idx;
    line_t     wr_line;

    // current valid bit of every slot
    logic [3:0] slot_valid;

    modport filler (
        output wr_en,
        output wr_idx,
        output wr_line,
        input  slot_valid
    );

    modport buffer (
        input  wr_en,
        input  wr_idx,
        input  wr_line,
        output slot_valid
    );

endinterface

/* verilog/ibuf_rd_if.sv */
`timescale 1ns/1ps

interface ibuf_rd_if
    import fetch_types_pkg::*;
();

    // stored lines and their valid bits
    line_t [3:0] lines;
    logic  [3:0] line_valid;

    // line release once bip has moved past it
    logic      rel_en;
    line_idx_t rel_idx;

    // flush on init or resteer, flush_idx is the target line
    logic      flush;
    line_idx_t flush_idx;

    modport buffer (
        output lines,
        output line_valid,
        input  rel_en,
        input  rel_idx,
        input  flush
    );

    modport aligner (
        input  lines,
        input  line_valid,
        output rel_en,
        output rel_idx,
        output flush,
        output flush_idx
    );

    // the filler only needs to see flushes
    modport watch (
        input flush,
        input flush_idx
    );

endinterface

/* verilog/line_filler.sv */
`timescale 1ns/1ps

module line_filler
    import fetch_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // fill port from memory
    input  line_t         fill_line,
    input  logic          fill_valid,
    output logic          fill_ready,

    ibuf_wr_if.filler     wr,
    ibuf_rd_if.watch      rd
);

    //////////////////////////////////////////////////
    // next slot to fill
    //////////////////////////////////////////////////

    line_idx_t slot_q;
    logic      take;

    // slot must be free, and no fill lands in a flush cycle
    assign fill_ready = ~wr.slot_valid[slot_q] & ~rd.flush;
    assign take       = fill_valid & fill_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (rd.flush) begin
            // restart filling at the new target line
            slot_q <= rd.flush_idx;
        end else if (take) begin
            // wraps from slot 3 back to slot 0
            slot_q <= slot_q + line_idx_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // write side of the buffer
    //////////////////////////////////////////////////

    assign wr.wr_en   = take;
    assign wr.wr_idx  = slot_q;
    assign wr.wr_line = fill_line;

endmodule

/* verilog/ibuf_lines.sv */
`timescale 1ns/1ps

module ibuf_lines
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    ibuf_wr_if.buffer wr,
    ibuf_rd_if.buffer rd
);

    //////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////

    line_t [NUM_LINES-1:0] data_q;
    logic  [NUM_LINES-1:0] valid_q;

    // line data from the filler
    always_ff @(posedge clk) begin
        if (wr.wr_en && !rd.flush) begin
            data_q[wr.wr_idx] <= wr.wr_line;
        end
    end

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (rd.flush) begin
            // flush wins over any write in the same cycle
            valid_q <= '0;
        end else begin
            if (wr.wr_en) begin
                valid_q[wr.wr_idx] <= 1'b1;
            end
            // release targets a valid slot, a write only a free one,
            // so the two never hit the same bit
            if (rd.rel_en) begin
                valid_q[rd.rel_idx] <= 1'b0;
            end
        end
    end

    // same valid bits seen by filler and aligner
    assign wr.slot_valid = valid_q;
    assign rd.line_valid = valid_q;
    assign rd.lines      = data_q;

endmodule

/* verilog/fetch_aligner.sv */
`timescale 1ns/1ps

module fetch_aligner
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    ibuf_rd_if.aligner  rd,

    // control flow flags and targets
    input  logic        cf_init,
    input  logic        cf_resteer,
    input  logic        cf_branch,
    input  bip_t        init_bip,
    input  bip_t        wb_bip,
    input  bip_t        bp_bip,

    // decode handshake
    input  len_t        decode_length,
    input  logic        decode_stall,
    output packet_t     packet,
    output logic        packet_valid,
    output bip_t        bip
);

    localparam int RING_BYTES = NUM_LINES * LINE_BYTES;

    bip_t      bip_q;
    bip_t      next_bip;
    bip_t      cf_bip;
    cf_src_t   cf_src;
    line_idx_t cur_line;
    line_idx_t nxt_line;
    logic      accept;
    logic      line_cross;

    logic [7:0] ring_bytes [RING_BYTES];

    //////////////////////////////////////////////////
    // control-flow select
    //////////////////////////////////////////////////

    // init over resteer over branch
    always_comb begin
        cf_src = CF_NONE;
        cf_bip = bp_bip;
        if (cf_init) begin
            cf_src = CF_INIT;
            cf_bip = init_bip;
        end else if (cf_resteer) begin
            cf_src = CF_RESTEER;
            cf_bip = wb_bip;
        end else if (cf_branch) begin
            cf_src = CF_BRANCH;
        end
    end

    //////////////////////////////////////////////////
    // bip register
    //////////////////////////////////////////////////

    assign cur_line     = bip_q[5:4];
    assign nxt_line     = cur_line + line_idx_t'(1);
    assign packet_valid = rd.line_valid[cur_line] & rd.line_valid[nxt_line];
    assign accept       = packet_valid & ~decode_stall;

    // modulo 64 add, upper length bits dropped
    assign next_bip   = bip_q + decode_length[5:0];
    assign line_cross = next_bip[5:4] != cur_line;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bip_q <= '0;
        end else if (cf_src != CF_NONE) begin
            bip_q <= cf_bip;
        end else if (accept) begin
            bip_q <= next_bip;
        end
    end

    assign bip = bip_q;

    // free the old line once bip leaves it
    assign rd.rel_en  = accept & line_cross & (cf_src == CF_NONE);
    assign rd.rel_idx = cur_line;

    // branch only moves bip, the lines stay
    assign rd.flush     = (cf_src == CF_INIT) | (cf_src == CF_RESTEER);
    assign rd.flush_idx = cf_bip[5:4];

    //////////////////////////////////////////////////
    // byte rotation
    //////////////////////////////////////////////////

    // flatten the ring, line 0 byte 0 first
    always_comb begin
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                ring_bytes[l*LINE_BYTES + b] = rd.lines[l][8*b +: 8];
            end
        end
    end

    // index wraps at 64 so line 3 runs into line 0
    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            packet[8*i +: 8] = ring_bytes[bip_q + bip_t'(i)];
        end
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
    import fetch_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // fill port
    input  line_t   fill_line,
    input  logic    fill_valid,
    output logic    fill_ready,

    // control flow
    input  logic    cf_init,
    input  bip_t    init_bip,
    input  logic    cf_resteer,
    input  bip_t    wb_bip,
    input  logic    cf_branch,
    input  bip_t    bp_bip,

    // decode side
    input  len_t    decode_length,
    input  logic    decode_stall,
    output packet_t packet,
    output logic    packet_valid,
    output bip_t    bip
);

    ibuf_wr_if wr_bus ();
    ibuf_rd_if rd_bus ();

    //////////////////////////////////////////////////
    // producer, buffer, consumer
    //////////////////////////////////////////////////

    line_filler filler0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_line  (fill_line),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .wr         (wr_bus.filler),
        .rd         (rd_bus.watch)
    );

    ibuf_lines ibuf0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus.buffer),
        .rd    (rd_bus.buffer)
    );

    fetch_aligner align0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd            (rd_bus.aligner),
        .cf_init       (cf_init),
        .cf_resteer    (cf_resteer),
        .cf_branch     (cf_branch),
        .init_bip      (init_bip),
        .wb_bip        (wb_bip),
        .bp_bip        (bp_bip),
        .decode_length (decode_length),
        .decode_stall  (decode_stall),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .bip           (bip)
    );

endmodule

/* tb/fetch_chk.sv */
`timescale 1ns/1ps

module fetch_chk
    import fetch_types_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    cf_init,
    input logic    cf_resteer,
    input logic    cf_branch,
    input logic    decode_stall,
    input logic    packet_valid,
    input packet_t packet,
    input bip_t    bip,
    input logic    flush
);

    logic any_cf;

    assign any_cf = cf_init | cf_resteer | cf_branch;

    // a stalled packet keeps both its lines and its bytes
    a_stall_pkt: assert property (@(posedge clk) disable iff (!rst_n)
        (packet_valid && decode_stall && !any_cf) |=> (packet_valid && $stable(packet)))
        else $error("packet changed or lost its lines during decode stall");

    // stall with no control flow freezes the pointer
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (decode_stall && !any_cf) |=> $stable(bip))
        else $error("bip moved during decode stall");

    // init or resteer leaves no valid line behind
    a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !packet_valid)
        else $error("packet_valid high right after a flush");

endmodule

bind fetch_aligner fetch_chk chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cf_init      (cf_init),
    .cf_resteer   (cf_resteer),
    .cf_branch    (cf_branch),
    .decode_stall (decode_stall),
    .packet_valid (packet_valid),
    .packet       (packet),
    .bip          (bip),
    .flush        (rd.flush)
);

/* tb/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
();

    localparam int RAND_CYCLES = 4000;
    localparam int WAIT_LIMIT  = 50;

    logic    clk;
    logic    rst_n;
    line_t   fill_line;
    logic    fill_valid;
    logic    fill_ready;
    logic    cf_init;
    bip_t    init_bip;
    logic    cf_resteer;
    bip_t    wb_bip;
    logic    cf_branch;
    bip_t    bp_bip;
    len_t    decode_length;
    logic    decode_stall;
    packet_t packet;
    logic    packet_valid;
    bip_t    bip;

    // ring model
    line_t     m_lines [NUM_LINES];
    logic      m_valid [NUM_LINES];
    bip_t      m_bip;
    line_idx_t m_slot;

    fetch_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .fill_line     (fill_line),
        .fill_valid    (fill_valid),
        .fill_ready    (fill_ready),
        .cf_init       (cf_init),
        .init_bip      (init_bip),
        .cf_resteer    (cf_resteer),
        .wb_bip        (wb_bip),
        .cf_branch     (cf_branch),
        .bp_bip        (bp_bip),
        .decode_length (decode_length),
        .decode_stall  (decode_stall),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .bip           (bip)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_packet(input packet_t got, input packet_t exp);
        if (got !== exp) begin
            report_error($sformatf("packet %h, expected %h", got, exp));
        end
    endtask

    task automatic check_bip(input bip_t got, input bip_t exp);
        if (got !== exp) begin
            report_error($sformatf("bip %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s %b, expected %b", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // model
    //////////////////////////////////////////////////

    function automatic logic model_valid();
        line_idx_t cur;
        line_idx_t nxt;
        cur = m_bip[5:4];
        nxt = cur + line_idx_t'(1);
        return m_valid[cur] && m_valid[nxt];
    endfunction

    // ring bytes from bip on, wrapping at 64
    function automatic packet_t model_packet();
        packet_t p;
        bip_t    idx;
        p = '0;
        for (int i = 0; i < LINE_BYTES; i++) begin
            idx = m_bip + bip_t'(i);
            p[8*i +: 8] = m_lines[idx[5:4]][8*idx[3:0] +: 8];
        end
        return p;
    endfunction

    function automatic line_t counting_line(input int base);
        line_t l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[8*i +: 8] = 8'(base + i);
        end
        return l;
    endfunction

    task automatic check_outputs();
        logic exp_valid;
        logic exp_ready;
        exp_valid = model_valid();
        exp_ready = !m_valid[m_slot] && !(cf_init || cf_resteer);
        check_bip(bip, m_bip);
        check_flag("packet_valid", packet_valid, exp_valid);
        check_flag("fill_ready", fill_ready, exp_ready);
        // bytes only mean something once both lines hold data
        if (exp_valid) begin
            check_packet(packet, model_packet());
        end
    endtask

    // next state after the coming clock edge
    task automatic update_model();
        cf_src_t src;
        bip_t    target;
        bip_t    next_bip;
        logic    ready;
        logic    accept;
        ready  = !m_valid[m_slot] && !(cf_init || cf_resteer);
        accept = model_valid() && !decode_stall;
        src    = CF_NONE;
        target = m_bip;
        if (cf_init) begin
            src    = CF_INIT;
            target = init_bip;
        end else if (cf_resteer) begin
            src    = CF_RESTEER;
            target = wb_bip;
        end else if (cf_branch) begin
            src    = CF_BRANCH;
            target = bp_bip;
        end
        if (src == CF_INIT || src == CF_RESTEER) begin
            for (int l = 0; l < NUM_LINES; l++) begin
                m_valid[l] = 1'b0;
            end
            m_slot = target[5:4];
            m_bip  = target;
        end else begin
            if (fill_valid && ready) begin
                m_lines[m_slot] = fill_line;
                m_valid[m_slot] = 1'b1;
                m_slot          = m_slot + line_idx_t'(1);
            end
            if (src == CF_BRANCH) begin
                m_bip = target;
            end else if (accept) begin
                next_bip = m_bip + decode_length[5:0];
                // leaving a line frees it
                if (next_bip[5:4] != m_bip[5:4]) begin
                    m_valid[m_bip[5:4]] = 1'b0;
                end
                m_bip = next_bip;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic set_idle();
        fill_line     = '0;
        fill_valid    = 1'b0;
        cf_init       = 1'b0;
        init_bip      = '0;
        cf_resteer    = 1'b0;
        wb_bip        = '0;
        cf_branch     = 1'b0;
        bp_bip        = '0;
        decode_length = len_t'(1);
        decode_stall  = 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        fill_line     = {$urandom(), $urandom(), $urandom(), $urandom()};
        fill_valid    = ($urandom() % 10) < 7;
        decode_stall  = ($urandom() % 4) == 0;
        decode_length = len_t'(1 + ($urandom() % 15));
        cf_init       = ($urandom() % 40) == 0;
        cf_resteer    = ($urandom() % 25) == 0;
        cf_branch     = ($urandom() % 12) == 0;
        r             = $urandom();
        init_bip      = r[5:0];
        wb_bip        = r[11:6];
        bp_bip        = r[17:12];
    endtask

    // check mid-cycle, then move to 1 ns past the next edge
    task automatic step();
        @(negedge clk);
        check_outputs();
        update_model();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_packet_valid();
        int cycles;
        cycles = 0;
        while (!packet_valid && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!packet_valid) begin
            $display("timed out after %0d cycles waiting for packet_valid", WAIT_LIMIT);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    endtask

    initial begin
        void'($urandom(32'ha9600369));
        rst_n = 1'b0;
        set_idle();
        for (int l = 0; l < NUM_LINES; l++) begin
            m_lines[l] = '0;
            m_valid[l] = 1'b0;
        end
        m_bip  = '0;
        m_slot = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_flag("packet_valid", packet_valid, 1'b0);
        check_bip(bip, '0);
        check_flag("fill_ready", fill_ready, 1'b1);

        // first two lines give bytes 0 to 15
        fill_valid = 1'b1;
        fill_line  = counting_line(0);
        step();
        fill_line  = counting_line(16);
        step();
        set_idle();
        wait_packet_valid();
        check_packet(packet, counting_line(0));

        repeat (RAND_CYCLES) begin
            drive_random();
            step();
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* src.f */
verilog/fetch_types_pkg.sv
verilog/fetch_ctrl_pkg.sv
verilog/ibuf_wr_if.sv
verilog/ibuf_rd_if.sv
verilog/line_filler.sv
verilog/ibuf_lines.sv
verilog/fetch_aligner.sv
verilog/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fetch testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module fetch_tb -f src.f -o fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL: run ended early"; exit 1; }
